// File: barrel_params.svh
// ######################################
// 800x600 at 60 Hz with a 40 MHz pixel clock
// colours are 12-bit rgb with 4 bits per channel
// ######################################

`ifndef BARREL_PARAMS_SVH
`define BARREL_PARAMS_SVH

// horizontal timing in pixels
`define H_ACTIVE 800
`define H_FRONT 40
`define H_SYNC 128
`define H_TOTAL 1056

// vertical timing in lines
`define V_ACTIVE 600
`define V_FRONT 1
`define V_SYNC 4
`define V_TOTAL 628

// sprite geometry, at most 16 barrels
`define BARREL_COUNT 5
`define BARREL_WIDTH 32
`define BARREL_HEIGHT 32

// scene colours and first ground row
`define GROUND_Y 480
`define COLOR_BLANK 12'h888
`define COLOR_SKY 12'h4AF
`define COLOR_GROUND 12'h630
`define COLOR_TRANSPARENT 12'h000

`endif

// File: barrel_pkg.sv
// ######################################
// vector types shared by the scene RTL and its testbench
// ######################################

package barrel_pkg;

    // pixel coordinate wide enough for the whole 1056x628 raster
    typedef logic [10:0] coord_t;

    // 4 bits each of red, green and blue, red in the top nibble
    typedef logic [11:0] rgb_t;

    // sprite address with the row in the upper 5 bits
    // and the column in the lower 5 bits
    typedef logic [9:0] sprite_addr_t;

endpackage

// File: vga_timing.sv
// ######################################
// free-running 800x600 raster counters
// sync pulses are active high
// ######################################

`timescale 1ns/1ps

`include "barrel_params.svh"

module vga_timing (
    input  logic               clk,
    input  logic               rst,
    output barrel_pkg::coord_t hcount,
    output barrel_pkg::coord_t vcount,
    output logic               hsync,
    output logic               vsync,
    output logic               hblnk,
    output logic               vblnk
);

    import barrel_pkg::*;

    localparam int HSYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int HSYNC_END   = `H_ACTIVE + `H_FRONT + `H_SYNC;
    localparam int VSYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int VSYNC_END   = `V_ACTIVE + `V_FRONT + `V_SYNC;

    coord_t hcount_nxt;
    coord_t vcount_nxt;

    // next raster position, line advances on pixel wrap
    always_comb begin
        if (hcount == coord_t'(`H_TOTAL - 1)) begin
            hcount_nxt = '0;
            if (vcount == coord_t'(`V_TOTAL - 1)) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + 1'b1;
            end
        end else begin
            hcount_nxt = hcount + 1'b1;
            vcount_nxt = vcount;
        end
    end

    // windows decoded from the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hblnk  <= (hcount_nxt >= `H_ACTIVE);
            vblnk  <= (vcount_nxt >= `V_ACTIVE);
            hsync  <= (hcount_nxt >= HSYNC_START) && (hcount_nxt < HSYNC_END);
            vsync  <= (vcount_nxt >= VSYNC_START) && (vcount_nxt < VSYNC_END);
        end
    end

endmodule

// File: draw_background.sv
// ######################################
// sky and ground fill, one clock of latency
// ######################################

`timescale 1ns/1ps

`include "barrel_params.svh"

module draw_background (
    input  logic               clk,
    input  logic               rst,
    input  barrel_pkg::coord_t in_hcount,
    input  barrel_pkg::coord_t in_vcount,
    input  logic               in_hsync,
    input  logic               in_vsync,
    input  logic               in_hblnk,
    input  logic               in_vblnk,
    output barrel_pkg::coord_t out_hcount,
    output barrel_pkg::coord_t out_vcount,
    output logic               out_hsync,
    output logic               out_vsync,
    output logic               out_hblnk,
    output logic               out_vblnk,
    output barrel_pkg::rgb_t   out_rgb
);

    import barrel_pkg::*;

    rgb_t rgb_nxt;

    always_comb begin
        if (in_hblnk || in_vblnk) begin
            rgb_nxt = `COLOR_BLANK;
        end else if (in_vcount >= `GROUND_Y) begin
            rgb_nxt = `COLOR_GROUND;
        end else begin
            rgb_nxt = `COLOR_SKY;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= in_hcount;
            out_vcount <= in_vcount;
            out_hsync  <= in_hsync;
            out_vsync  <= in_vsync;
            out_hblnk  <= in_hblnk;
            out_vblnk  <= in_vblnk;
            out_rgb    <= rgb_nxt;
        end
    end

endmodule

// File: delay.sv
// ######################################
// fixed-length shift register, CLK_DEL must be 1 or more
// ######################################

`timescale 1ns/1ps

module delay #(
    parameter int WIDTH   = 8,
    parameter int CLK_DEL = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // stage 0 takes din, the last stage drives dout
    logic [WIDTH-1:0] stage [CLK_DEL];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CLK_DEL; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < CLK_DEL; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[CLK_DEL-1];

endmodule

// File: barrel_rom.sv
// ######################################
// 32x32 barrel sprite, black corners are transparent
// read data appears one clock after addr
// ######################################

`timescale 1ns/1ps

`include "barrel_params.svh"

module barrel_rom (
    input  logic                     clk,
    input  barrel_pkg::sprite_addr_t addr,
    output barrel_pkg::rgb_t         data
);

    import barrel_pkg::*;

    // width of the clipped corner squares
    localparam int CORNER = 4;

    rgb_t mem [2**$bits(sprite_addr_t)];

    function automatic rgb_t sprite_entry(input int row, input int col);
        logic row_edge;
        logic col_edge;
        row_edge = (row < CORNER) || (row > `BARREL_HEIGHT - 1 - CORNER);
        col_edge = (col < CORNER) || (col > `BARREL_WIDTH - 1 - CORNER);
        if (row_edge && col_edge) begin
            return `COLOR_TRANSPARENT;
        end
        // shade runs along both axes, blue stays fixed
        return {4'(row / 2), 4'(col / 2), 4'hA};
    endfunction

    initial begin
        for (int r = 0; r < `BARREL_HEIGHT; r++) begin
            for (int c = 0; c < `BARREL_WIDTH; c++) begin
                mem[{5'(r), 5'(c)}] = sprite_entry(r, c);
            end
        end
    end

    always_ff @(posedge clk) begin
        data <= mem[addr];
    end

endmodule

// File: draw_barrel.sv
// ######################################
// overlays up to 16 barrel sprites, highest index on top
// three clocks of latency, sprite ROM read takes one of them
// ######################################

`timescale 1ns/1ps

`include "barrel_params.svh"

module draw_barrel #(
    parameter int BARRELS = `BARREL_COUNT
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 game_en,
    // high while an animation runs, barrels are hidden then
    input  logic                                 animation,
    input  logic               [BARRELS-1:0]     barrel,
    input  barrel_pkg::coord_t [BARRELS-1:0]     xpos,
    input  barrel_pkg::coord_t [BARRELS-1:0]     ypos,
    input  barrel_pkg::coord_t                   in_hcount,
    input  barrel_pkg::coord_t                   in_vcount,
    input  logic                                 in_hsync,
    input  logic                                 in_vsync,
    input  logic                                 in_hblnk,
    input  logic                                 in_vblnk,
    input  barrel_pkg::rgb_t                     in_rgb,
    output barrel_pkg::sprite_addr_t             sprite_addr,
    input  barrel_pkg::rgb_t                     sprite_rgb,
    output barrel_pkg::coord_t                   out_hcount,
    output barrel_pkg::coord_t                   out_vcount,
    output logic                                 out_hsync,
    output logic                                 out_vsync,
    output logic                                 out_hblnk,
    output logic                                 out_vblnk,
    output barrel_pkg::rgb_t                     out_rgb
);

    import barrel_pkg::*;

    localparam int BUNDLE_W = 2 * $bits(coord_t) + 4 + $bits(rgb_t);

    coord_t       hcount_d;
    coord_t       vcount_d;
    logic         hsync_d;
    logic         vsync_d;
    logic         hblnk_d;
    logic         vblnk_d;
    rgb_t         rgb_d;

    logic         hit_nxt;
    sprite_addr_t addr_nxt;
    logic         hit_q;
    logic         hit_d;
    rgb_t         rgb_nxt;

    // ######################################
    // bundle delay, lines up with the ROM output
    // ######################################

    delay #(
        .WIDTH   (BUNDLE_W),
        .CLK_DEL (2)
    ) u_delay (
        .clk,
        .rst,
        .din  ({in_hcount, in_vcount, in_hsync, in_vsync, in_hblnk, in_vblnk, in_rgb}),
        .dout ({hcount_d, vcount_d, hsync_d, vsync_d, hblnk_d, vblnk_d, rgb_d})
    );

    // ######################################
    // hit test and sprite address
    // ######################################

    // later barrels overwrite earlier ones so the highest index wins
    always_comb begin
        coord_t dx;
        coord_t dy;
        hit_nxt  = 1'b0;
        addr_nxt = sprite_addr;
        for (int i = 0; i < BARRELS; i++) begin
            dx = in_hcount - xpos[i];
            dy = in_vcount - ypos[i];
            if (barrel[i] &&
                (in_hcount >= xpos[i]) && (in_hcount < xpos[i] + `BARREL_WIDTH) &&
                (in_vcount >= ypos[i]) && (in_vcount < ypos[i] + `BARREL_HEIGHT)) begin
                hit_nxt  = 1'b1;
                addr_nxt = {dy[4:0], dx[4:0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q       <= 1'b0;
            hit_d       <= 1'b0;
            sprite_addr <= '0;
        end else begin
            hit_q       <= hit_nxt;
            hit_d       <= hit_q;
            sprite_addr <= addr_nxt;
        end
    end

    // ######################################
    // output stage
    // ######################################

    always_comb begin
        if (hblnk_d || vblnk_d) begin
            rgb_nxt = `COLOR_BLANK;
        end else if (hit_d && game_en && !animation && (sprite_rgb != `COLOR_TRANSPARENT)) begin
            rgb_nxt = sprite_rgb;
        end else begin
            rgb_nxt = rgb_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= hcount_d;
            out_vcount <= vcount_d;
            out_hsync  <= hsync_d;
            out_vsync  <= vsync_d;
            out_hblnk  <= hblnk_d;
            out_vblnk  <= vblnk_d;
            out_rgb    <= rgb_nxt;
        end
    end

endmodule

// File: barrel_scene.sv
// ######################################
// scene top, outputs trail the raster counters by 4 clocks
// change barrel inputs only while vblnk is high
// ######################################

`timescale 1ns/1ps

`include "barrel_params.svh"

module barrel_scene (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    game_en,
    input  logic                                    animation,
    input  logic               [`BARREL_COUNT-1:0]  barrel,
    input  barrel_pkg::coord_t [`BARREL_COUNT-1:0]  xpos,
    input  barrel_pkg::coord_t [`BARREL_COUNT-1:0]  ypos,
    output barrel_pkg::coord_t                      hcount,
    output barrel_pkg::coord_t                      vcount,
    output logic                                    hsync,
    output logic                                    vsync,
    output logic                                    hblnk,
    output logic                                    vblnk,
    output barrel_pkg::rgb_t                        rgb
);

    import barrel_pkg::*;

    // raster timing
    coord_t       tim_hcount;
    coord_t       tim_vcount;
    logic         tim_hsync;
    logic         tim_vsync;
    logic         tim_hblnk;
    logic         tim_vblnk;

    // background stage
    coord_t       bg_hcount;
    coord_t       bg_vcount;
    logic         bg_hsync;
    logic         bg_vsync;
    logic         bg_hblnk;
    logic         bg_vblnk;
    rgb_t         bg_rgb;

    // sprite ROM port
    sprite_addr_t sprite_addr;
    rgb_t         sprite_rgb;

    vga_timing u_vga_timing (
        .clk,
        .rst,
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk)
    );

    draw_background u_draw_background (
        .clk,
        .rst,
        .in_hcount  (tim_hcount),
        .in_vcount  (tim_vcount),
        .in_hsync   (tim_hsync),
        .in_vsync   (tim_vsync),
        .in_hblnk   (tim_hblnk),
        .in_vblnk   (tim_vblnk),
        .out_hcount (bg_hcount),
        .out_vcount (bg_vcount),
        .out_hsync  (bg_hsync),
        .out_vsync  (bg_vsync),
        .out_hblnk  (bg_hblnk),
        .out_vblnk  (bg_vblnk),
        .out_rgb    (bg_rgb)
    );

    draw_barrel #(
        .BARRELS (`BARREL_COUNT)
    ) u_draw_barrel (
        .clk,
        .rst,
        .game_en,
        .animation,
        .barrel,
        .xpos,
        .ypos,
        .in_hcount   (bg_hcount),
        .in_vcount   (bg_vcount),
        .in_hsync    (bg_hsync),
        .in_vsync    (bg_vsync),
        .in_hblnk    (bg_hblnk),
        .in_vblnk    (bg_vblnk),
        .in_rgb      (bg_rgb),
        .sprite_addr (sprite_addr),
        .sprite_rgb  (sprite_rgb),
        .out_hcount  (hcount),
        .out_vcount  (vcount),
        .out_hsync   (hsync),
        .out_vsync   (vsync),
        .out_hblnk   (hblnk),
        .out_vblnk   (vblnk),
        .out_rgb     (rgb)
    );

    barrel_rom u_barrel_rom (
        .clk,
        .addr (sprite_addr),
        .data (sprite_rgb)
    );

endmodule

// File: barrel_asserts.sv
// ######################################
// output checks bound into barrel_scene
// ######################################

`timescale 1ns/1ps

`include "barrel_params.svh"

module barrel_asserts (
    input logic               clk,
    input logic               rst,
    input barrel_pkg::coord_t hcount,
    input barrel_pkg::coord_t vcount,
    input logic               hsync,
    input logic               hblnk,
    input logic               vblnk,
    input barrel_pkg::rgb_t   rgb
);

    import barrel_pkg::*;

    blank_is_grey: assert property (@(posedge clk) disable iff (rst)
        (hblnk || vblnk) |-> (rgb == `COLOR_BLANK))
        else $error("rgb is not grey during blanking");

    counters_in_range: assert property (@(posedge clk) disable iff (rst)
        (hcount < `H_TOTAL) && (vcount < `V_TOTAL))
        else $error("raster counter beyond the frame");

    // horizontal sync sits inside the blanking interval
    hsync_in_blank: assert property (@(posedge clk) disable iff (rst)
        hsync |-> hblnk)
        else $error("hsync high outside horizontal blanking");

endmodule

bind barrel_scene barrel_asserts u_asserts (
    .clk    (clk),
    .rst    (rst),
    .hcount (hcount),
    .vcount (vcount),
    .hsync  (hsync),
    .hblnk  (hblnk),
    .vblnk  (vblnk),
    .rgb    (rgb)
);

// File: tb_barrel_scene.sv
// ######################################
// frame-by-frame check of barrel_scene against a reference model
// each table row stays in force for one whole frame
// ######################################

`timescale 1ns/1ps

`include "barrel_params.svh"

module tb_barrel_scene;

    import barrel_pkg::*;

    localparam int BARRELS       = `BARREL_COUNT;
    localparam int ROWS          = 6;
    localparam int FRAME_TIMEOUT = `H_TOTAL * `V_TOTAL + 100;

    logic                       clk;
    logic                       rst;
    logic                       game_en;
    logic                       animation;
    logic         [BARRELS-1:0] barrel;
    coord_t       [BARRELS-1:0] xpos;
    coord_t       [BARRELS-1:0] ypos;
    coord_t                     hcount;
    coord_t                     vcount;
    logic                       hsync;
    logic                       vsync;
    logic                       hblnk;
    logic                       vblnk;
    rgb_t                       rgb;

    // scenario table, one entry per frame
    logic               row_en   [ROWS];
    logic               row_anim [ROWS];
    logic [BARRELS-1:0] row_mask [ROWS];
    int                 row_x    [ROWS][BARRELS];
    int                 row_y    [ROWS][BARRELS];

    int          cur_row;
    logic        check_en;
    int          checks;
    int          errors;
    logic        timed_out;
    logic [31:0] lfsr_state;
    int          prev_h;
    int          prev_v;
    logic        prev_valid;

    barrel_scene uut (
        .clk       (clk),
        .rst       (rst),
        .game_en   (game_en),
        .animation (animation),
        .barrel    (barrel),
        .xpos      (xpos),
        .ypos      (ypos),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync     (hsync),
        .vsync     (vsync),
        .hblnk     (hblnk),
        .vblnk     (vblnk),
        .rgb       (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ######################################
    // reference model
    // ######################################

    // clipped corners are 4x4 squares
    function automatic int sprite_color(input int r, input int c);
        bit r_lo;
        bit r_hi;
        bit c_lo;
        bit c_hi;
        r_lo = (r < 4);
        r_hi = (r > 27);
        c_lo = (c < 4);
        c_hi = (c > 27);
        if ((r_lo && c_lo) || (r_hi && c_hi) || (r_lo && c_hi) || (r_hi && c_lo)) begin
            return 0;
        end
        return ((r / 2) << 8) | ((c / 2) << 4) | 'hA;
    endfunction

    // the highest enabled barrel containing the pixel decides, even when transparent
    function automatic int expected_rgb(input int h, input int v);
        int bg;
        int s;
        if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
            return `COLOR_BLANK;
        end
        bg = (v >= `GROUND_Y) ? `COLOR_GROUND : `COLOR_SKY;
        if (!row_en[cur_row] || row_anim[cur_row]) begin
            return bg;
        end
        for (int i = BARRELS - 1; i >= 0; i--) begin
            if (row_mask[cur_row][i] &&
                h >= row_x[cur_row][i] && h < row_x[cur_row][i] + `BARREL_WIDTH &&
                v >= row_y[cur_row][i] && v < row_y[cur_row][i] + `BARREL_HEIGHT) begin
                s = sprite_color(v - row_y[cur_row][i], h - row_x[cur_row][i]);
                return (s == `COLOR_TRANSPARENT) ? bg : s;
            end
        end
        return bg;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("ERROR %s expected %h actual %h at h=%0d v=%0d",
                     name, expected, actual, hcount, vcount);
        end
    endtask

    always @(posedge clk) begin : output_check
        int exp_h;
        int exp_v;
        if (check_en) begin
            if (prev_valid) begin
                exp_h = (prev_h == `H_TOTAL - 1) ? 0 : prev_h + 1;
                exp_v = prev_v;
                if (prev_h == `H_TOTAL - 1) begin
                    exp_v = (prev_v == `V_TOTAL - 1) ? 0 : prev_v + 1;
                end
                check_value("hcount", exp_h, int'(hcount));
                check_value("vcount", exp_v, int'(vcount));
            end
            check_value("hblnk", int'(hcount >= `H_ACTIVE), int'(hblnk));
            check_value("vblnk", int'(vcount >= `V_ACTIVE), int'(vblnk));
            check_value("hsync", int'(hcount >= `H_ACTIVE + `H_FRONT &&
                                      hcount < `H_ACTIVE + `H_FRONT + `H_SYNC), int'(hsync));
            check_value("vsync", int'(vcount >= `V_ACTIVE + `V_FRONT &&
                                      vcount < `V_ACTIVE + `V_FRONT + `V_SYNC), int'(vsync));
            check_value("rgb", expected_rgb(hcount, vcount), int'(rgb));
            prev_h     = hcount;
            prev_v     = vcount;
            prev_valid = 1'b1;
        end
    end

    // ######################################
    // stimulus
    // ######################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic load_table();
        // background only, barrels enabled but game off
        row_en[0]   = 1'b0;
        row_anim[0] = 1'b0;
        row_mask[0] = 5'b11111;
        row_x[0] = '{100, 200, 300, 400, 500};
        row_y[0] = '{100, 200, 300, 400, 500};
        // one barrel
        row_en[1]   = 1'b1;
        row_anim[1] = 1'b0;
        row_mask[1] = 5'b00001;
        row_x[1] = '{100, 0, 0, 0, 0};
        row_y[1] = '{100, 0, 0, 0, 0};
        // barrel 1 corner over barrel 0, barrel 2 across the ground line
        row_en[2]   = 1'b1;
        row_anim[2] = 1'b0;
        row_mask[2] = 5'b00111;
        row_x[2] = '{200, 216, 400, 0, 0};
        row_y[2] = '{300, 316, 465, 0, 0};
        // animation hides everything
        row_en[3]   = 1'b1;
        row_anim[3] = 1'b1;
        row_mask[3] = 5'b11111;
        row_x[3] = '{100, 200, 300, 400, 500};
        row_y[3] = '{100, 150, 200, 250, 300};
        // only barrels 2 and 4 enabled
        row_en[4]   = 1'b1;
        row_anim[4] = 1'b0;
        row_mask[4] = 5'b10100;
        row_x[4] = '{100, 200, 300, 400, 500};
        row_y[4] = '{100, 150, 200, 250, 300};
    endtask

    // second-to-last barrel clipped at the right edge, last one at the bottom
    task automatic fill_random_row(input int idx);
        int v;
        row_en[idx]   = 1'b1;
        row_anim[idx] = 1'b0;
        row_mask[idx] = '1;
        for (int i = 0; i < BARRELS; i++) begin
            take_bits(10, v);
            if (i == BARRELS - 2) begin
                row_x[idx][i] = `H_ACTIVE - 30 + v % 30;
            end else begin
                row_x[idx][i] = v % (`H_ACTIVE - `BARREL_WIDTH);
            end
            take_bits(10, v);
            if (i == BARRELS - 1) begin
                row_y[idx][i] = `V_ACTIVE - 30 + v % 30;
            end else begin
                row_y[idx][i] = v % (`V_ACTIVE - `BARREL_HEIGHT);
            end
        end
    endtask

    task automatic apply_row(input int idx);
        cur_row   = idx;
        game_en   = row_en[idx];
        animation = row_anim[idx];
        barrel    = row_mask[idx];
        for (int i = 0; i < BARRELS; i++) begin
            xpos[i] = coord_t'(row_x[idx][i]);
            ypos[i] = coord_t'(row_y[idx][i]);
        end
    endtask

    // returns on a falling edge with vblnk at the wanted level
    task automatic wait_vblnk(input logic level, output logic expired);
        int n;
        n = 0;
        while (vblnk !== level && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        expired = (vblnk !== level);
        if (expired) begin
            $display("timeout: vblnk did not go to %0b within one frame", level);
        end
    endtask

    initial begin
        rst        = 1'b1;
        game_en    = 1'b0;
        animation  = 1'b0;
        barrel     = '0;
        xpos       = '0;
        ypos       = '0;
        check_en   = 1'b0;
        checks     = 0;
        errors     = 0;
        timed_out  = 1'b0;
        cur_row    = 0;
        prev_h     = 0;
        prev_v     = 0;
        prev_valid = 1'b0;
        lfsr_state = 32'h27ea;
        load_table();
        fill_random_row(ROWS - 1);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // inputs change only inside vertical blanking
        for (int r = 0; r < ROWS && !timed_out; r++) begin
            wait_vblnk(1'b1, timed_out);
            if (!timed_out) begin
                apply_row(r);
                check_en = 1'b1;
                wait_vblnk(1'b0, timed_out);
            end
        end
        if (!timed_out) begin
            wait_vblnk(1'b1, timed_out);
        end
        check_en = 1'b0;

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
barrel_pkg.sv
vga_timing.sv
draw_background.sv
delay.sv
barrel_rom.sv
draw_barrel.sv
barrel_scene.sv
barrel_asserts.sv
tb_barrel_scene.sv

// File: Makefile
# Verilator build and run for the barrel scene testbench

VERILATOR  ?= verilator
TB_TOP     ?= tb_barrel_scene
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG   ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
